// ==== source/panel_pkg.sv ====
package panel_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Button bundle.
    ////////////////////////////////////////////////////////////////////////////

    // Prev sits in bit 0, cancel in bit 3.
    // The same struct carries raw levels and press pulses.
    typedef struct packed {
        logic cancel;
        logic okay;
        logic next;
        logic prev;
    } buttons_t;

    ////////////////////////////////////////////////////////////////////////////
    // Menu layout.
    ////////////////////////////////////////////////////////////////////////////

    // Menu item index, 0 to 14.
    typedef logic [3:0] cursor_t;

    // Option code inside one group.
    typedef logic [2:0] option_t;

    // Highest cursor index.
    localparam cursor_t MENU_LAST = 4'd14;

    // Items per group.
    localparam int GROUP_SIZE = 5;

    // First item of each group.
    localparam cursor_t PERIOD_BASE = cursor_t'(0);
    localparam cursor_t GAIN_BASE = cursor_t'(GROUP_SIZE);
    localparam cursor_t TIME_BASE = cursor_t'(2 * GROUP_SIZE);

    typedef enum logic [1:0] {
        GROUP_PERIOD = 2'd0,
        GROUP_GAIN   = 2'd1,
        GROUP_TIME   = 2'd2
    } menu_group_e;

    ////////////////////////////////////////////////////////////////////////////
    // Setting encodings.
    ////////////////////////////////////////////////////////////////////////////

    // Number of drawn sine periods.
    typedef enum logic [2:0] {
        PERIODS_1 = 3'd0,
        PERIODS_2 = 3'd1,
        PERIODS_3 = 3'd2,
        PERIODS_4 = 3'd3,
        PERIODS_5 = 3'd4
    } periods_e;

    // Pulse-counter gain divider.
    // Code 0 is only the divider symbol on screen.
    typedef enum logic [2:0] {
        DIV_NONE = 3'd0,
        DIV_1    = 3'd1,
        DIV_2    = 3'd2,
        DIV_4    = 3'd3,
        DIV_8    = 3'd4
    } gain_div_e;

    // Time-interval selection.
    typedef enum logic [2:0] {
        TIME_0 = 3'd0,
        TIME_1 = 3'd1,
        TIME_2 = 3'd2,
        TIME_3 = 3'd3,
        TIME_4 = 3'd4
    } time_sel_e;

    // Committed display settings, 9 bits.
    typedef struct packed {
        periods_e  periods;
        gain_div_e gain_div;
        time_sel_e time_sel;
    } settings_t;

endpackage

// ==== source/button_conditioner.sv ====
`timescale 1ns/1ps

module button_conditioner #(
    parameter int DEBOUNCE_CYCLES = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  panel_pkg::buttons_t buttons,
    output panel_pkg::buttons_t presses
);

    // Counter must be able to hold DEBOUNCE_CYCLES - 1.
    localparam int CNT_W = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_CYCLES - 1);

    // Flat view of the button bundle.
    logic [3:0] raw_levels;
    logic [3:0] press_q;

    assign raw_levels = buttons;

    ////////////////////////////////////////////////////////////////////////////
    // One conditioner per button.
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < 4; i++) begin : g_button
        // Two-stage synchronizer.
        logic sync_0;
        logic sync_1;
        // Debounced level.
        logic stable;
        // Cycles the synced level has differed from stable.
        logic [CNT_W-1:0] cnt;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                sync_0 <= 1'b0;
                sync_1 <= 1'b0;
            end else begin
                sync_0 <= raw_levels[i];
                sync_1 <= sync_0;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stable     <= 1'b0;
                cnt        <= '0;
                press_q[i] <= 1'b0;
            end else begin
                // Pulse lasts one cycle by default.
                press_q[i] <= 1'b0;
                if (sync_1 != stable) begin
                    if (cnt == CNT_LAST) begin
                        // Held long enough, accept the new level.
                        stable     <= sync_1;
                        cnt        <= '0;
                        // Only a rising flip counts as a press.
                        press_q[i] <= sync_1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end else begin
                    // Glitch ended early, start over.
                    cnt <= '0;
                end
            end
        end
    end

    assign presses = panel_pkg::buttons_t'(press_q);

endmodule

// ==== source/menu_controller.sv ====
`timescale 1ns/1ps

module menu_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  panel_pkg::buttons_t   presses,
    output panel_pkg::cursor_t    cursor,
    output panel_pkg::option_t    option,
    output logic                  clear,
    output logic                  load_periods,
    output logic                  load_gain,
    output logic                  load_time,
    output logic                  undo_periods,
    output logic                  undo_gain,
    output logic                  undo_time
);

    panel_pkg::cursor_t     cursor_q;
    panel_pkg::cursor_t     group_base;
    panel_pkg::cursor_t     item_offset;
    panel_pkg::menu_group_e group;

    // Press after priority resolution.
    logic okay_hit;
    logic cancel_hit;

    ////////////////////////////////////////////////////////////////////////////
    // Cursor register.
    ////////////////////////////////////////////////////////////////////////////

    // Prev wins over next.
    // Both wrap at the menu ends.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cursor_q <= '0;
        end else if (!en) begin
            // Disabled panel parks the cursor.
            cursor_q <= '0;
        end else if (presses.prev) begin
            if (cursor_q == '0) begin
                cursor_q <= panel_pkg::MENU_LAST;
            end else begin
                cursor_q <= cursor_q - 1'b1;
            end
        end else if (presses.next) begin
            if (cursor_q == panel_pkg::MENU_LAST) begin
                cursor_q <= '0;
            end else begin
                cursor_q <= cursor_q + 1'b1;
            end
        end
    end

    assign cursor = cursor_q;

    ////////////////////////////////////////////////////////////////////////////
    // Cursor decode.
    ////////////////////////////////////////////////////////////////////////////

    // Group from the item range.
    always_comb begin
        if (cursor_q < panel_pkg::GAIN_BASE) begin
            group      = panel_pkg::GROUP_PERIOD;
            group_base = panel_pkg::PERIOD_BASE;
        end else if (cursor_q < panel_pkg::TIME_BASE) begin
            group      = panel_pkg::GROUP_GAIN;
            group_base = panel_pkg::GAIN_BASE;
        end else begin
            group      = panel_pkg::GROUP_TIME;
            group_base = panel_pkg::TIME_BASE;
        end
    end

    // Offset into the group, always below GROUP_SIZE.
    assign item_offset = cursor_q - group_base;
    assign option      = panel_pkg::option_t'(item_offset);

    ////////////////////////////////////////////////////////////////////////////
    // Strobes.
    ////////////////////////////////////////////////////////////////////////////

    assign clear = ~en;

    // Okay and cancel lose to any cursor move in the same cycle.
    assign okay_hit   = en & ~presses.prev & ~presses.next & presses.okay;
    assign cancel_hit = en & ~presses.prev & ~presses.next & ~presses.okay
                        & presses.cancel;

    // Exactly one group sees each hit.
    assign load_periods = okay_hit & (group == panel_pkg::GROUP_PERIOD);
    assign load_gain    = okay_hit & (group == panel_pkg::GROUP_GAIN);
    assign load_time    = okay_hit & (group == panel_pkg::GROUP_TIME);

    assign undo_periods = cancel_hit & (group == panel_pkg::GROUP_PERIOD);
    assign undo_gain    = cancel_hit & (group == panel_pkg::GROUP_GAIN);
    assign undo_time    = cancel_hit & (group == panel_pkg::GROUP_TIME);

endmodule

// ==== source/setting_slot.sv ====
`timescale 1ns/1ps

module setting_slot #(
    parameter type      payload_t = logic [2:0],
    parameter payload_t DEFAULT   = payload_t'(0)
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clear,
    input  logic               load,
    input  logic               undo,
    input  panel_pkg::option_t option,
    output payload_t           value
);

    // Committed setting.
    payload_t value_q;
    // Setting before the last load.
    payload_t prev_q;

    ////////////////////////////////////////////////////////////////////////////
    // Commit and undo.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value_q <= DEFAULT;
            prev_q  <= DEFAULT;
        end else if (clear) begin
            // Panel disabled, back to defaults.
            value_q <= DEFAULT;
            prev_q  <= DEFAULT;
        end else if (load) begin
            prev_q  <= value_q;
            value_q <= payload_t'(option);
        end else if (undo) begin
            // Prev stays, so a repeat undo is a no-op.
            value_q <= prev_q;
        end
    end

    assign value = value_q;

endmodule

// ==== source/front_panel_top.sv ====
`timescale 1ns/1ps

module front_panel_top #(
    parameter int DEBOUNCE_CYCLES = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 en,
    input  panel_pkg::buttons_t  buttons,
    output panel_pkg::cursor_t   cursor,
    output panel_pkg::settings_t settings
);

    panel_pkg::buttons_t presses;
    panel_pkg::option_t  option;
    logic                clear;
    logic                load_periods;
    logic                load_gain;
    logic                load_time;
    logic                undo_periods;
    logic                undo_gain;
    logic                undo_time;

    panel_pkg::periods_e  periods;
    panel_pkg::gain_div_e gain_div;
    panel_pkg::time_sel_e time_sel;

    ////////////////////////////////////////////////////////////////////////////
    // Buttons and menu.
    ////////////////////////////////////////////////////////////////////////////

    button_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) button_conditioner_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .buttons (buttons),
        .presses (presses)
    );

    menu_controller menu_controller_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .presses      (presses),
        .cursor       (cursor),
        .option       (option),
        .clear        (clear),
        .load_periods (load_periods),
        .load_gain    (load_gain),
        .load_time    (load_time),
        .undo_periods (undo_periods),
        .undo_gain    (undo_gain),
        .undo_time    (undo_time)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Setting slots.
    ////////////////////////////////////////////////////////////////////////////

    // Sine periods, one period by default.
    setting_slot #(
        .payload_t (panel_pkg::periods_e),
        .DEFAULT   (panel_pkg::PERIODS_1)
    ) periods_slot_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .load   (load_periods),
        .undo   (undo_periods),
        .option (option),
        .value  (periods)
    );

    // Gain divider, code 0 is never the default.
    setting_slot #(
        .payload_t (panel_pkg::gain_div_e),
        .DEFAULT   (panel_pkg::DIV_1)
    ) gain_slot_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .load   (load_gain),
        .undo   (undo_gain),
        .option (option),
        .value  (gain_div)
    );

    // Time interval, same reason as the divider.
    setting_slot #(
        .payload_t (panel_pkg::time_sel_e),
        .DEFAULT   (panel_pkg::TIME_1)
    ) time_slot_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .load   (load_time),
        .undo   (undo_time),
        .option (option),
        .value  (time_sel)
    );

    assign settings = '{periods: periods, gain_div: gain_div, time_sel: time_sel};

endmodule

// ==== bench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock.
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released on a falling edge, away from the flops.
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== bench/panel_checker.sv ====
`timescale 1ns/1ps

module panel_checker (
    input  logic                 clk,
    input  logic                 check,
    input  panel_pkg::cursor_t   exp_cursor,
    input  panel_pkg::settings_t exp_settings,
    input  panel_pkg::cursor_t   cursor,
    input  panel_pkg::settings_t settings,
    output int                   error_count,
    output int                   check_count
);

    int errors = 0;
    int checks = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Compare at the rising edge, before the DUT registers update.
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (check) begin
            checks = checks + 1;
            if (cursor !== exp_cursor) begin
                errors = errors + 1;
                $display("MISMATCH at time %0t: step %0d cursor is %0d, expected %0d",
                         $time, checks, cursor, exp_cursor);
            end
            if (settings.periods !== exp_settings.periods) begin
                errors = errors + 1;
                $display("MISMATCH at time %0t: step %0d periods is %0d, expected %0d",
                         $time, checks, settings.periods, exp_settings.periods);
            end
            if (settings.gain_div !== exp_settings.gain_div) begin
                errors = errors + 1;
                $display("MISMATCH at time %0t: step %0d gain_div is %0d, expected %0d",
                         $time, checks, settings.gain_div, exp_settings.gain_div);
            end
            if (settings.time_sel !== exp_settings.time_sel) begin
                errors = errors + 1;
                $display("MISMATCH at time %0t: step %0d time_sel is %0d, expected %0d",
                         $time, checks, settings.time_sel, exp_settings.time_sel);
            end
        end
    end

    assign error_count = errors;
    assign check_count = checks;

endmodule

// ==== bench/panel_tb.sv ====
`timescale 1ns/1ps

module panel_tb;

    localparam int          DEBOUNCE_CYCLES = 8;
    localparam int          CLK_PERIOD_NS   = 20;
    localparam logic [15:0] LFSR_SEED       = 16'd41498;
    localparam string       STIM_FILE       = "bench/panel_stim.txt";

    // One line of the stim file.
    typedef struct packed {
        panel_pkg::buttons_t  btn;
        logic [7:0]           hold;
        logic [7:0]           rel;
        logic                 bounce;
        logic                 en;
        panel_pkg::cursor_t   cursor;
        panel_pkg::settings_t settings;
    } step_t;

    logic                 clk;
    logic                 rst_n;
    logic                 en;
    panel_pkg::buttons_t  buttons;
    panel_pkg::cursor_t   cursor;
    panel_pkg::settings_t settings;

    logic                 check_req;
    panel_pkg::cursor_t   exp_cursor;
    panel_pkg::settings_t exp_settings;
    int                   error_count;
    int                   check_count;

    step_t       steps[$];
    logic [15:0] lfsr_state;
    int          watchdog_cycles;
    logic        stim_loaded;

    clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (4)
    ) clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    front_panel_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) front_panel_top_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .en       (en),
        .buttons  (buttons),
        .cursor   (cursor),
        .settings (settings)
    );

    panel_checker panel_checker_inst (
        .clk          (clk),
        .check        (check_req),
        .exp_cursor   (exp_cursor),
        .exp_settings (exp_settings),
        .cursor       (cursor),
        .settings     (settings),
        .error_count  (error_count),
        .check_count  (check_count)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Bounce source.
    ////////////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per bit.
    task automatic take_bits(input int count, output int value);
        value = 0;
        repeat (count) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus.
    ////////////////////////////////////////////////////////////////////////////

    task automatic read_stim(output bit ok);
        int    fd;
        int    fields;
        string line;
        int    btn, hold, rel, bounce, en_lvl, cur, per, gain, tsel;
        ok = 1'b0;
        watchdog_cycles = 1000;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            // Comment and blank lines do not parse and drop out here.
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                                 btn, hold, rel, bounce, en_lvl, cur, per, gain, tsel);
                if (fields == 9) begin
                    steps.push_back('{
                        btn:      panel_pkg::buttons_t'(btn[3:0]),
                        hold:     hold[7:0],
                        rel:      rel[7:0],
                        bounce:   bounce[0],
                        en:       en_lvl[0],
                        cursor:   panel_pkg::cursor_t'(cur[3:0]),
                        settings: panel_pkg::settings_t'({per[2:0], gain[2:0], tsel[2:0]})
                    });
                    watchdog_cycles = watchdog_cycles + hold + rel;
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    // Entered and left on a falling edge.
    task automatic run_step(input step_t st);
        int bursts;
        int len;
        int gap;
        en = st.en;
        if (st.bounce) begin
            // Bursts of 1 to 7 cycles, all below the debounce length.
            take_bits(3, bursts);
            if (bursts == 0) begin
                bursts = 1;
            end
            repeat (bursts) begin
                take_bits(3, len);
                buttons = st.btn;
                repeat ((len % 7) + 1) @(negedge clk);
                take_bits(3, gap);
                buttons = '0;
                repeat ((gap % 7) + 1) @(negedge clk);
            end
        end
        buttons = st.btn;
        repeat (int'(st.hold)) @(negedge clk);
        buttons = '0;
        repeat (int'(st.rel)) @(negedge clk);
        exp_cursor   = st.cursor;
        exp_settings = st.settings;
        check_req    = 1'b1;
        @(negedge clk);
        check_req    = 1'b0;
    endtask

    initial begin
        bit stim_ok;
        en           = 1'b1;
        buttons      = '0;
        check_req    = 1'b0;
        exp_cursor   = '0;
        exp_settings = '0;
        lfsr_state   = LFSR_SEED;
        stim_loaded  = 1'b0;
        read_stim(stim_ok);
        if (!stim_ok) begin
            $display("ERROR: could not open the stimulus file %s", STIM_FILE);
            $display("*** FAILED ***");
        end else begin
            stim_loaded = 1'b1;
            wait (rst_n === 1'b1);
            @(negedge clk);
            foreach (steps[s]) begin
                run_step(steps[s]);
            end
            if (check_count != steps.size() || steps.size() == 0) begin
                $display("ERROR: %0d of %0d stim steps were checked", check_count, steps.size());
            end
            $display("Steps checked: %0d, errors: %0d", check_count, error_count);
            if (error_count == 0 && check_count == steps.size() && steps.size() > 0) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
        end
        $finish;
    end

    // Watchdog, sized from the stim file.
    initial begin
        wait (stim_loaded === 1'b1);
        #(watchdog_cycles * CLK_PERIOD_NS);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== bench/panel_stim.txt ====
// Hex fields: button bits (cancel okay next prev), hold cycles, release cycles, bounce, en
// then expected cursor, periods, gain_div, time_sel
0 00 04 0 1 0 0 1 1
1 0c 0e 0 1 e 0 1 1
2 0c 0e 0 1 0 0 1 1
2 0c 0e 1 1 1 0 1 1
2 0c 0e 0 1 2 0 1 1
4 0c 0e 0 1 2 2 1 1
2 0c 0e 0 1 3 2 1 1
2 0c 0e 1 1 4 2 1 1
2 0c 0e 0 1 5 2 1 1
4 0c 0e 0 1 5 2 0 1
2 0c 0e 0 1 6 2 0 1
2 0c 0e 0 1 7 2 0 1
2 0c 0e 0 1 8 2 0 1
4 0c 0e 0 1 8 2 3 1
8 0c 0e 0 1 8 2 0 1
8 0c 0e 1 1 8 2 0 1
2 0c 0e 0 1 9 2 0 1
2 0c 0e 0 1 a 2 0 1
4 0c 0e 0 1 a 2 0 0
2 0c 0e 0 1 b 2 0 0
2 0c 0e 0 1 c 2 0 0
4 0c 0e 0 1 c 2 0 2
8 0c 0e 0 1 c 2 0 0
8 0c 0e 0 1 c 2 0 0
3 0c 0e 0 1 b 2 0 0
4 0c 0e 0 1 b 2 0 1
2 0c 0e 0 0 0 0 1 1
4 0c 0e 0 0 0 0 1 1
0 00 0e 0 1 0 0 1 1
2 0c 0e 0 1 1 0 1 1
4 0c 0e 0 1 1 1 1 1

// ==== files.f ====
source/panel_pkg.sv
source/button_conditioner.sv
source/menu_controller.sv
source/setting_slot.sv
source/front_panel_top.sv
bench/clock_gen.sv
bench/panel_checker.sv
bench/panel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the front panel testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module panel_tb -f files.f -o panel_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/panel_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
